// File: axil_mem_subsys.f
+incdir+include
verilog/axil_pkg.sv
verilog/axil_read_engine.sv
verilog/axil_write_engine.sv
verilog/axil_cpu_port.sv
verilog/axil_sram.sv
verilog/axil_mem_subsys.sv
sim/tb_axil_mem_subsys.sv

// File: Makefile
# Verilator build and run for the AXI-lite memory subsystem

VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps
TOP       := tb_axil_mem_subsys
FLIST     := axil_mem_subsys.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_axil_mem_subsys.sv
// Testbench for the AXI-lite memory subsystem with a shadow memory reference model
module tb_axil_mem_subsys
  import axil_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_DEPTH   = 256;
  localparam int WAIT_CYCLES = 2;
  localparam int IDX_W       = $clog2(MEM_DEPTH);
  localparam int TIMEOUT     = 200;  // Cycles allowed per request

  logic    i_aclk = 1'b0;
  logic    i_rst_n;
  logic    i_rw_valid;
  rw_req_t i_rw_req;
  logic    o_rw_addr_ok;
  logic    o_rw_data_ok;
  rw_rsp_t o_rw_rsp;

  logic [AXIL_DATA_W-1:0] shadow [MEM_DEPTH];
  rw_rsp_t                exp_q [$];   // Expected responses in issue order
  integer                 seed        = 64;
  int                     addr_ok_cnt = 0;
  int                     data_ok_cnt = 0;
  int                     err_cnt     = 0;
  int                     check_cnt   = 0;
  int                     test_no     = 0;
  int                     test_err0   = 0;
  logic                   abort_run   = 1'b0;

  axil_mem_subsys #(.MEM_DEPTH(MEM_DEPTH), .WAIT_CYCLES(WAIT_CYCLES)) axil_mem_subsys_i (
    .i_aclk, .i_rst_n, .i_rw_valid, .i_rw_req, .o_rw_addr_ok, .o_rw_data_ok, .o_rw_rsp
  );

  always #5 i_aclk = ~i_aclk;

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  function automatic logic [AXIL_DATA_W-1:0] fill_word(logic [AXIL_ADDR_W-1:0] addr);
    return {addr ^ 32'h5a5a_c3c3, ~addr};
  endfunction

  function automatic logic [AXIL_DATA_W-1:0] merge_bytes(logic [AXIL_DATA_W-1:0] old,
                                                          logic [AXIL_DATA_W-1:0] data,
                                                          logic [AXIL_STRB_W-1:0] strb);
    logic [AXIL_DATA_W-1:0] mask;
    for (int b = 0; b < AXIL_STRB_W; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (old & ~mask) | (data & mask);
  endfunction

  // Expected response from the shadow memory and the range rule
  function automatic rw_rsp_t ref_rsp(rw_req_t req);
    rw_rsp_t                rsp;
    logic [AXIL_ADDR_W-1:0] idx;
    idx       = req.addr >> AXIL_OFFS_W;
    rsp.op    = req.op;
    rsp.resp  = (idx < MEM_DEPTH) ? RESP_OKAY : RESP_SLVERR;
    rsp.rdata = '0;
    if (req.op == OP_READ && idx < MEM_DEPTH) rsp.rdata = shadow[idx[IDX_W-1:0]];
    return rsp;
  endfunction

  function automatic void update_shadow(rw_req_t req);
    logic [AXIL_ADDR_W-1:0] idx;
    idx = req.addr >> AXIL_OFFS_W;
    if (req.op == OP_WRITE && idx < MEM_DEPTH) begin
      shadow[idx[IDX_W-1:0]] = merge_bytes(shadow[idx[IDX_W-1:0]], req.wdata, req.wstrb);
    end
  endfunction

  // ---------------------------------------------------------------------------
  // Compare tasks
  // ---------------------------------------------------------------------------
  task automatic check_data(rw_rsp_t got, rw_rsp_t want);
    check_cnt++;
    if (got.rdata !== want.rdata || got.op !== want.op) begin
      err_cnt++;
      $display("mismatch at %0t: op %b rdata %h, expected op %b rdata %h",
               $time, got.op, got.rdata, want.op, want.rdata);
    end
  endtask

  task automatic expect_resp(axil_resp_e got, axil_resp_e want);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("mismatch at %0t: resp %b, expected %b", $time, got, want);
    end
  endtask

  task automatic verify_count(string what, int got, int want);
    check_cnt++;
    if (got != want) begin
      err_cnt++;
      $display("mismatch at %0t: %0d %s pulses, expected %0d", $time, got, what, want);
    end
  endtask

  // Scoreboard, one expected response per data_ok
  always @(negedge i_aclk) begin : compare_rsp
    rw_rsp_t want;
    if (o_rw_data_ok) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("error at %0t: data_ok pulsed with no request outstanding", $time);
      end else begin
        want = exp_q.pop_front();
        check_data(o_rw_rsp, want);
        expect_resp(o_rw_rsp.resp, want.resp);
      end
    end
  end

  always @(negedge i_aclk) begin
    if (o_rw_addr_ok) addr_ok_cnt++;
    if (o_rw_data_ok) data_ok_cnt++;
  end

  always @(posedge abort_run) begin
    $display("RESULT: FAIL");
    $finish;
  end

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------
  // Holds valid until data_ok, then counts the handshake pulses
  task automatic issue(rw_op_e op, logic [AXIL_ADDR_W-1:0] addr,
                       logic [AXIL_DATA_W-1:0] wdata, logic [AXIL_STRB_W-1:0] wstrb);
    rw_req_t req;
    int      addr_ok0;
    int      data_ok0;
    int      cycles;
    req      = '{op: op, addr: addr, wdata: wdata, wstrb: wstrb};
    addr_ok0 = addr_ok_cnt;
    data_ok0 = data_ok_cnt;
    cycles   = 0;
    exp_q.push_back(ref_rsp(req));
    update_shadow(req);
    i_rw_req   = req;
    i_rw_valid = 1'b1;
    while (!o_rw_data_ok && cycles < TIMEOUT) begin
      @(negedge i_aclk);
      cycles++;
    end
    if (!o_rw_data_ok) begin
      $display("timeout: no data_ok within %0d cycles for the request at address %h",
               TIMEOUT, addr);
      abort_run = 1'b1;
      forever @(negedge i_aclk);
    end
    @(negedge i_aclk);  // Still high on the edge that ends data_ok, as a clocked CPU
    i_rw_valid = 1'b0;
    repeat (2 * WAIT_CYCLES + 4) @(negedge i_aclk);  // Room for a duplicate issue to show up
    verify_count("addr_ok", addr_ok_cnt - addr_ok0, 1);
    verify_count("data_ok", data_ok_cnt - data_ok0, 1);
  endtask

  task automatic finish_test(string name);
    test_no++;
    $display("test %0d %s: %s, %0d errors", test_no, name,
             (err_cnt == test_err0) ? "ok" : "failed", err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  initial begin : main
    logic [AXIL_ADDR_W-1:0] addr;
    logic [AXIL_DATA_W-1:0] data;
    int                     idx;
    int                     addr_ok0;
    int                     data_ok0;
    i_rst_n    = 1'b0;
    i_rw_valid = 1'b0;
    i_rw_req   = '0;
    repeat (5) @(negedge i_aclk);
    i_rst_n = 1'b1;

    // Quiet bus, no pulses expected
    addr_ok0 = addr_ok_cnt;
    data_ok0 = data_ok_cnt;
    repeat (20) @(negedge i_aclk);
    verify_count("addr_ok", addr_ok_cnt - addr_ok0, 0);
    verify_count("data_ok", data_ok_cnt - data_ok0, 0);
    finish_test("idle after reset");

    // Every word written once, which also fills the shadow memory
    for (idx = 0; idx < MEM_DEPTH; idx++) begin
      addr = AXIL_ADDR_W'(idx) << AXIL_OFFS_W;
      issue(OP_WRITE, addr, fill_word(addr), '1);
      issue(OP_READ, addr, '0, '0);
    end
    finish_test("full-strobe write and read back");

    for (idx = 0; idx < 8; idx++) begin
      addr = AXIL_ADDR_W'((idx * 37) % MEM_DEPTH) << AXIL_OFFS_W;
      issue(OP_WRITE, addr, {$random(seed), $random(seed)}, 8'h0f);
      issue(OP_WRITE, addr, {$random(seed), $random(seed)}, 8'ha5);
      issue(OP_WRITE, addr, {$random(seed), $random(seed)}, AXIL_STRB_W'($random(seed)));
      issue(OP_READ, addr, '0, '0);
    end
    finish_test("partial-strobe byte merge");

    issue(OP_WRITE, AXIL_ADDR_W'(MEM_DEPTH) << AXIL_OFFS_W, '1, '1);
    issue(OP_WRITE, AXIL_ADDR_W'(MEM_DEPTH + 5) << AXIL_OFFS_W, '1, '1);
    issue(OP_WRITE, 32'hffff_fff8, '1, '1);
    issue(OP_READ, AXIL_ADDR_W'(MEM_DEPTH) << AXIL_OFFS_W, '0, '0);
    issue(OP_READ, 32'hffff_fff8, '0, '0);
    issue(OP_READ, 32'h0000_0000, '0, '0);  // Alias of word MEM_DEPTH if truncated
    issue(OP_READ, 32'h0000_0028, '0, '0);  // Word 5
    issue(OP_READ, AXIL_ADDR_W'(MEM_DEPTH - 1) << AXIL_OFFS_W, '0, '0);
    finish_test("out-of-range SLVERR");

    for (idx = 0; idx < 6; idx++) begin
      data = {$random(seed), $random(seed)};
      issue(OP_WRITE, 32'h0000_0018, data, '1);
      issue(OP_READ, 32'h0000_0018, '0, '0);
    end
    finish_test("one addr_ok and one data_ok per request");

    // Roughly one in nine addresses lands past the end
    for (idx = 0; idx < 100; idx++) begin
      addr = AXIL_ADDR_W'($unsigned($random(seed)) % (MEM_DEPTH + MEM_DEPTH / 8));
      addr = addr << AXIL_OFFS_W;
      data = {$random(seed), $random(seed)};
      issue(($random(seed) & 1) ? OP_WRITE : OP_READ, addr, data,
            AXIL_STRB_W'($random(seed)));
    end
    finish_test("random mixed traffic");

    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("error: %0d expected responses never arrived", exp_q.size());
    end
    $display("tests %0d, checks %0d, errors %0d", test_no, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/axil_mem_subsys.sv
// Memory subsystem top, CPU port and AXI-lite engines in front of the SRAM slave
module axil_mem_subsys
  import axil_pkg::*;
#(
  parameter int MEM_DEPTH   = 256,
  parameter int WAIT_CYCLES = 2
) (
  input  logic    i_aclk,
  input  logic    i_rst_n,
  input  logic    i_rw_valid,
  input  rw_req_t i_rw_req,
  output logic    o_rw_addr_ok,
  output logic    o_rw_data_ok,
  output rw_rsp_t o_rw_rsp
);

  // Port to engines
  logic    rd_start;
  logic    wr_start;
  rw_req_t req;
  logic    rd_addr_done;
  logic    wr_addr_done;
  logic    rd_done;
  logic    wr_done;
  axil_r_t rd_r;
  axil_b_t wr_b;

  // AXI-lite channels
  logic     awvalid;
  logic     awready;
  axil_aw_t aw;
  logic     wvalid;
  logic     wready;
  axil_w_t  w;
  logic     bvalid;
  logic     bready;
  axil_b_t  b;
  logic     arvalid;
  logic     arready;
  axil_aw_t ar;
  logic     rvalid;
  logic     rready;
  axil_r_t  r;

  axil_cpu_port cpu_port_i (
    .i_aclk, .i_rst_n, .i_rw_valid, .i_rw_req, .o_rw_addr_ok, .o_rw_data_ok, .o_rw_rsp,
    .o_rd_start(rd_start), .o_wr_start(wr_start), .o_req(req),
    .i_rd_addr_done(rd_addr_done), .i_wr_addr_done(wr_addr_done),
    .i_rd_done(rd_done), .i_rd_r(rd_r), .i_wr_done(wr_done), .i_wr_b(wr_b)
  );

  axil_read_engine read_engine_i (
    .i_aclk, .i_rst_n, .i_start(rd_start), .i_req(req),
    .o_arvalid(arvalid), .o_ar(ar), .i_arready(arready),
    .i_rvalid(rvalid), .i_r(r), .o_rready(rready),
    .o_addr_done(rd_addr_done), .o_done(rd_done), .o_r(rd_r)
  );

  axil_write_engine write_engine_i (
    .i_aclk, .i_rst_n, .i_start(wr_start), .i_req(req),
    .o_awvalid(awvalid), .o_aw(aw), .i_awready(awready),
    .o_wvalid(wvalid), .o_w(w), .i_wready(wready),
    .i_bvalid(bvalid), .i_b(b), .o_bready(bready),
    .o_addr_done(wr_addr_done), .o_done(wr_done), .o_b(wr_b)
  );

  axil_sram #(.MEM_DEPTH(MEM_DEPTH), .WAIT_CYCLES(WAIT_CYCLES)) sram_i (
    .i_aclk, .i_rst_n,
    .i_awvalid(awvalid), .i_aw(aw), .o_awready(awready),
    .i_wvalid(wvalid), .i_w(w), .o_wready(wready),
    .o_bvalid(bvalid), .o_b(b), .i_bready(bready),
    .i_arvalid(arvalid), .i_ar(ar), .o_arready(arready),
    .o_rvalid(rvalid), .o_r(r), .i_rready(rready)
  );

endmodule

// File: verilog/axil_sram.sv
// AXI-lite SRAM slave with ready wait cycles and word range checking
module axil_sram
  import axil_pkg::*;
#(
  parameter int MEM_DEPTH   = 256,
  parameter int WAIT_CYCLES = 2
) (
  input  logic     i_aclk,
  input  logic     i_rst_n,
  input  logic     i_awvalid,
  input  axil_aw_t i_aw,
  output logic     o_awready,
  input  logic     i_wvalid,
  input  axil_w_t  i_w,
  output logic     o_wready,
  output logic     o_bvalid,
  output axil_b_t  o_b,
  input  logic     i_bready,
  input  logic     i_arvalid,
  input  axil_aw_t i_ar,
  output logic     o_arready,
  output logic     o_rvalid,
  output axil_r_t  o_r,
  input  logic     i_rready
);

  localparam int WORD_W = AXIL_ADDR_W - AXIL_OFFS_W;
  localparam int IDX_W  = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
  localparam int CNT_W  = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
  localparam logic [WORD_W-1:0] DEPTH_WORDS = WORD_W'(MEM_DEPTH);
  localparam logic [CNT_W-1:0]  WAIT_LAST   = CNT_W'(WAIT_CYCLES);

  logic [AXIL_DATA_W-1:0] mem [MEM_DEPTH];

  // Channel slots, 0 AW, 1 W, 2 AR
  logic [2:0]       chan_valid;
  logic [2:0]       chan_open;
  logic [2:0]       chan_ready;
  logic [CNT_W-1:0] wait_cnt [3];

  logic                   aw_got_q;
  logic                   w_got_q;
  logic                   bvalid_q;
  logic                   rvalid_q;
  logic [AXIL_ADDR_W-1:0] aw_addr_q;
  axil_w_t                w_q;
  axil_b_t                b_q;
  axil_r_t                r_q;

  logic                   wr_go;
  logic [AXIL_ADDR_W-1:0] wr_addr;
  axil_w_t                wr_beat;
  logic [WORD_W-1:0]      wr_word;
  logic [WORD_W-1:0]      rd_word;
  logic                   wr_hit;
  logic                   rd_hit;

  // ---------------------------------------------------------------------------
  // Ready generation, a channel waits WAIT_CYCLES with valid high
  // ---------------------------------------------------------------------------
  assign chan_valid = {i_arvalid, i_wvalid, i_awvalid};
  assign chan_open  = {~rvalid_q, ~w_got_q & ~bvalid_q, ~aw_got_q & ~bvalid_q};

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      chan_ready[i] = chan_valid[i] & chan_open[i] & (wait_cnt[i] == WAIT_LAST);
    end
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 3; i++) begin
        wait_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (!chan_valid[i] || chan_ready[i]) begin
          wait_cnt[i] <= '0;
        end else if (wait_cnt[i] != WAIT_LAST) begin
          wait_cnt[i] <= wait_cnt[i] + CNT_W'(1);  // Saturates while blocked
        end
      end
    end
  end

  // Write goes ahead once AW and W are both in, same-cycle fire counts
  assign wr_go   = (aw_got_q | chan_ready[0]) & (w_got_q | chan_ready[1]);
  assign wr_addr = aw_got_q ? aw_addr_q : i_aw.addr;
  assign wr_beat = w_got_q ? w_q : i_w;
  assign wr_word = wr_addr[AXIL_ADDR_W-1:AXIL_OFFS_W];
  assign wr_hit  = (wr_word < DEPTH_WORDS);
  assign rd_word = i_ar.addr[AXIL_ADDR_W-1:AXIL_OFFS_W];
  assign rd_hit  = (rd_word < DEPTH_WORDS);

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_go) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
        bvalid_q <= 1'b1;
      end else begin
        if (chan_ready[0]) aw_got_q <= 1'b1;
        if (chan_ready[1]) w_got_q <= 1'b1;
        if (i_bready) bvalid_q <= 1'b0;
      end
      if (chan_ready[2]) begin
        rvalid_q <= 1'b1;
      end else if (i_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Storage and channel payloads
  // ---------------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (chan_ready[0]) aw_addr_q <= i_aw.addr;
    if (chan_ready[1]) w_q <= i_w;
    if (wr_go) b_q.resp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    if (wr_go && wr_hit) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (wr_beat.strb[b]) mem[wr_word[IDX_W-1:0]][8*b +: 8] <= wr_beat.data[8*b +: 8];
      end
    end
    if (chan_ready[2]) begin
      r_q.data <= rd_hit ? mem[rd_word[IDX_W-1:0]] : '0;  // Out of range reads zero
      r_q.resp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign o_awready = chan_ready[0];
  assign o_wready  = chan_ready[1];
  assign o_arready = chan_ready[2];
  assign o_bvalid  = bvalid_q;
  assign o_b       = b_q;
  assign o_rvalid  = rvalid_q;
  assign o_r       = r_q;

endmodule

// File: verilog/axil_cpu_port.sv
// CPU request port, dispatches one request to an engine and returns one response
module axil_cpu_port
  import axil_pkg::*;
(
  input  logic    i_aclk,
  input  logic    i_rst_n,
  input  logic    i_rw_valid,
  input  rw_req_t i_rw_req,
  output logic    o_rw_addr_ok,
  output logic    o_rw_data_ok,
  output rw_rsp_t o_rw_rsp,
  output logic    o_rd_start,
  output logic    o_wr_start,
  output rw_req_t o_req,
  input  logic    i_rd_addr_done,
  input  logic    i_wr_addr_done,
  input  logic    i_rd_done,
  input  axil_r_t i_rd_r,
  input  logic    i_wr_done,
  input  axil_b_t i_wr_b
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_DONE   // One dead cycle, the held request is ignored
  } port_state_e;

  port_state_e state_q;
  logic        rd_start_q;
  logic        wr_start_q;
  logic        accept;
  logic        eng_done;
  rw_req_t     req_q;
  rw_rsp_t     rsp_q;
  rw_rsp_t     done_rsp;

  assign accept   = (state_q == ST_IDLE) & i_rw_valid;
  assign eng_done = i_rd_done | i_wr_done;

  always_comb begin
    if (i_rd_done) begin
      done_rsp = '{rdata: i_rd_r.data, resp: i_rd_r.resp, op: OP_READ};
    end else begin
      done_rsp = '{rdata: '0, resp: i_wr_b.resp, op: OP_WRITE};
    end
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q    <= ST_IDLE;
      rd_start_q <= 1'b0;
      wr_start_q <= 1'b0;
    end else begin
      rd_start_q <= accept & (i_rw_req.op == OP_READ);
      wr_start_q <= accept & (i_rw_req.op == OP_WRITE);
      case (state_q)
        ST_IDLE: if (i_rw_valid) state_q <= ST_BUSY;
        ST_BUSY: if (eng_done) state_q <= ST_DONE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge i_aclk) begin
    if (accept) req_q <= i_rw_req;
    if ((state_q == ST_BUSY) && eng_done) rsp_q <= done_rsp;
  end

  assign o_rd_start   = rd_start_q;
  assign o_wr_start   = wr_start_q;
  assign o_req        = req_q;
  assign o_rw_addr_ok = i_rd_addr_done | i_wr_addr_done;
  assign o_rw_data_ok = (state_q == ST_DONE);
  assign o_rw_rsp     = rsp_q;

endmodule

// File: verilog/axil_write_engine.sv
// AXI-lite write engine, runs AW then W then waits for the B response
`include "axil_defines.svh"

module axil_write_engine
  import axil_pkg::*;
(
  input  logic     i_aclk,
  input  logic     i_rst_n,
  input  logic     i_start,
  input  rw_req_t  i_req,
  output logic     o_awvalid,
  output axil_aw_t o_aw,
  input  logic     i_awready,
  output logic     o_wvalid,
  output axil_w_t  o_w,
  input  logic     i_wready,
  input  logic     i_bvalid,
  input  axil_b_t  i_b,
  output logic     o_bready,
  output logic     o_addr_done,
  output logic     o_done,
  output axil_b_t  o_b
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  localparam logic [AXIL_PROT_W-1:0] WR_PROT =
    `AXIL_PROT_UNPRIV | `AXIL_PROT_SECURE | `AXIL_PROT_DATA;

  wr_state_e state_q;
  wr_state_e state_d;
  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;

  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid & i_wready;
  assign b_fire  = o_bready & i_bvalid;

  // ---------------------------------------------------------------------------
  // Channel sequencing, each step waits for a real handshake
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: if (i_start) state_d = WR_ADDR;
      WR_ADDR: if (aw_fire) state_d = WR_DATA;
      WR_DATA: if (w_fire) state_d = WR_RESP;
      WR_RESP: if (b_fire) state_d = WR_IDLE;
      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign o_awvalid   = (state_q == WR_ADDR);
  assign o_aw        = '{addr: i_req.addr, prot: WR_PROT};
  assign o_wvalid    = (state_q == WR_DATA);
  assign o_w         = '{data: i_req.wdata, strb: i_req.wstrb};
  assign o_bready    = (state_q == WR_RESP);
  assign o_addr_done = w_fire;  // CPU sees addr_ok once data is taken
  assign o_done      = b_fire;
  assign o_b         = i_b;

endmodule

// File: verilog/axil_read_engine.sv
// AXI-lite read engine, issues AR from the request and accepts one R beat
`include "axil_defines.svh"

module axil_read_engine
  import axil_pkg::*;
(
  input  logic     i_aclk,
  input  logic     i_rst_n,
  input  logic     i_start,
  input  rw_req_t  i_req,      // Held stable by the port
  output logic     o_arvalid,
  output axil_aw_t o_ar,
  input  logic     i_arready,
  input  logic     i_rvalid,
  input  axil_r_t  i_r,
  output logic     o_rready,
  output logic     o_addr_done,
  output logic     o_done,
  output axil_r_t  o_r
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

  localparam logic [AXIL_PROT_W-1:0] RD_PROT =
    `AXIL_PROT_UNPRIV | `AXIL_PROT_SECURE | `AXIL_PROT_DATA;

  rd_state_e state_q;
  rd_state_e state_d;
  logic      ar_fire;
  logic      r_fire;

  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = o_rready & i_rvalid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: if (i_start) state_d = RD_ADDR;
      RD_ADDR: if (ar_fire) state_d = RD_DATA;  // Slave stall keeps us here
      RD_DATA: if (r_fire) state_d = RD_IDLE;
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign o_arvalid   = (state_q == RD_ADDR);
  assign o_ar        = '{addr: i_req.addr, prot: RD_PROT};
  assign o_rready    = (state_q == RD_DATA);
  assign o_addr_done = ar_fire;
  assign o_done      = r_fire;
  assign o_r         = i_r;    // Sampled by the port on done

endmodule

// File: verilog/axil_pkg.sv
// Widths, enums and packed payload types for the AXI-lite memory subsystem
`include "axil_defines.svh"

package axil_pkg;

  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 64;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
  localparam int AXIL_OFFS_W = $clog2(AXIL_STRB_W);  // Byte offset in a word
  localparam int AXIL_PROT_W = 3;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } rw_op_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = `AXIL_RESP_OKAY,
    RESP_SLVERR = `AXIL_RESP_SLVERR
  } axil_resp_e;

  // CPU side request and response
  typedef struct packed {
    rw_op_e                   op;
    logic [AXIL_ADDR_W-1:0] addr;
    logic [AXIL_DATA_W-1:0] wdata;
    logic [AXIL_STRB_W-1:0] wstrb;
  } rw_req_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0] rdata;
    axil_resp_e               resp;
    rw_op_e                   op;  // Which engine finished
  } rw_rsp_t;

  // AXI-lite channel payloads, AR reuses the AW type
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] addr;
    logic [AXIL_PROT_W-1:0] prot;
  } axil_aw_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    logic [AXIL_STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    axil_resp_e               resp;
  } axil_r_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

endpackage

// File: include/axil_defines.svh
// AXI-lite protection bits and response codes shared by the bridge and the slave
`ifndef AXIL_DEFINES_SVH
`define AXIL_DEFINES_SVH

// ---------------------------------------------------------------------------
// AxPROT bit values, each one a cleared bit in its own position
// ---------------------------------------------------------------------------
`define AXIL_PROT_UNPRIV 3'b000  // Bit 0 low
`define AXIL_PROT_SECURE 3'b000  // Bit 1 low
`define AXIL_PROT_DATA   3'b000  // Bit 2 low

// ---------------------------------------------------------------------------
// xRESP encodings
// ---------------------------------------------------------------------------
`define AXIL_RESP_OKAY   2'b00
`define AXIL_RESP_SLVERR 2'b10   // Slave error, bad word index

`endif
